// ==== include/cluster_defs.svh ====
/*
 * Widths, DCR address map and credit count for the fill cluster.
 * DCR_SOCKET_STRIDE must be a power of two. The arbiter is two-way only,
 * so NUM_SOCKETS stays at 2.
 */
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

`default_nettype none

// ********************
// Bus widths
// ********************
`define DCR_ADDR_W          12
`define DCR_DATA_W          32
`define MEM_ADDR_W          32
`define MEM_DATA_W          32

// ********************
// DCR map and sizing
// ********************
`define DCR_SOCKET_BEGIN    12'h010
`define DCR_SOCKET_END      12'h018
`define DCR_SOCKET_STRIDE   4

`define MEM_CREDITS         4
`define NUM_SOCKETS         2

`default_nettype wire

`endif

// ==== design/cluster_pkg.sv ====
/*
 * Shared types for the fill cluster.
 * Offset 3 of a socket's DCR range is reserved.
 */
`include "cluster_defs.svh"

`default_nettype none

package cluster_pkg;

    // Register offset inside one socket's DCR range
    typedef enum logic [1:0] {
        REG_BASE  = 2'd0,
        REG_CFG   = 2'd1,
        REG_START = 2'd2
    } dcr_reg_e;

    // One DCR data word, two decodings.
    // REG_BASE and REG_START use the flat view, REG_CFG the count/stride pair
    typedef union packed {
        logic [`DCR_DATA_W-1:0] base;
        struct packed {
            logic [`DCR_DATA_W/2-1:0] count;
            logic [`DCR_DATA_W/2-1:0] stride;
        } cfg;
    } dcr_data_u;

endpackage

`default_nettype wire

// ==== design/dcr_router.sv ====
/*
 * Filters DCR writes to the socket range and registers one strobe per socket.
 * Output lags the DCR write by one cycle. Writes to offset 3 are dropped.
 */
`include "cluster_defs.svh"

`default_nettype none

module dcr_router import cluster_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        dcr_write_valid,
    input  wire  [`DCR_ADDR_W-1:0]     dcr_write_addr,
    input  wire  dcr_data_u            dcr_write_data,

    output logic [`NUM_SOCKETS-1:0]    reg_write,
    output dcr_reg_e                   reg_sel,
    output dcr_data_u                  reg_data
);

    localparam int OFF_W = $clog2(`DCR_SOCKET_STRIDE);

    logic                     in_range;
    logic [`DCR_ADDR_W-1:0]   rel_addr;
    dcr_reg_e                 sel;
    logic [`NUM_SOCKETS-1:0]  write_hit;

    assign in_range = dcr_write_valid
                   && (dcr_write_addr >= `DCR_SOCKET_BEGIN)
                   && (dcr_write_addr <  `DCR_SOCKET_END);

    assign rel_addr = dcr_write_addr - `DCR_SOCKET_BEGIN;
    assign sel      = dcr_reg_e'(rel_addr[OFF_W-1:0]);

    // Upper bits of the offset pick the socket
    always_comb begin
        for (int i = 0; i < `NUM_SOCKETS; i++) begin
            write_hit[i] = in_range
                        && (sel inside {REG_BASE, REG_CFG, REG_START})
                        && (rel_addr[`DCR_ADDR_W-1:OFF_W] == (`DCR_ADDR_W - OFF_W)'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write <= '0;
        end else begin
            reg_write <= write_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (|write_hit) begin
            reg_sel  <= sel;
            reg_data <= dcr_write_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/fill_socket.sv ====
/*
 * Strided write generator. Writes to a busy socket are dropped, REG_START too.
 * Request k carries base + k * stride and seed + k. A zero count starts nothing.
 */
`include "cluster_defs.svh"

`default_nettype none

module fill_socket import cluster_pkg::*; #(
    // Index within the cluster, picks this socket's strobe bit in the top
    parameter int SOCKET_ID = 0
) (
    input  wire                        clk,
    input  wire                        rst_n,

    input  wire                        reg_write,
    input  wire  dcr_reg_e             reg_sel,
    input  wire  dcr_data_u            reg_data,

    output logic                       req_valid,
    output logic [`MEM_ADDR_W-1:0]     req_addr,
    output logic [`MEM_DATA_W-1:0]     req_data,
    input  wire                        req_ready,

    output logic                       busy
);

    localparam int HALF_W = `DCR_DATA_W / 2;

    logic [`MEM_ADDR_W-1:0]  base_addr;
    logic [HALF_W-1:0]       cfg_count;
    logic [HALF_W-1:0]       cfg_stride;

    logic                    active;
    logic [HALF_W-1:0]       remaining;
    logic [`MEM_ADDR_W-1:0]  cur_addr;
    logic [`MEM_DATA_W-1:0]  cur_data;

    logic                    cfg_write;
    logic                    xfer;

    assign cfg_write = reg_write && !active;
    assign xfer      = active && req_ready;

    // ********************
    // Job control
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            remaining <= '0;
            cfg_count <= '0;
        end else if (cfg_write) begin
            case (reg_sel)
                REG_CFG: cfg_count <= reg_data.cfg.count;
                REG_START: begin
                    remaining <= cfg_count;
                    active    <= (cfg_count != '0);
                end
                default: ;
            endcase
        end else if (xfer) begin
            remaining <= remaining - 1'b1;
            // Last transfer
            if (remaining == HALF_W'(1)) begin
                active <= 1'b0;
            end
        end
    end

    // Address and data accumulators
    always_ff @(posedge clk) begin
        if (cfg_write) begin
            case (reg_sel)
                REG_BASE: base_addr <= `MEM_ADDR_W'(reg_data.base);
                REG_CFG:  cfg_stride <= reg_data.cfg.stride;
                REG_START: begin
                    cur_addr <= base_addr;
                    cur_data <= `MEM_DATA_W'(reg_data.base);
                end
                default: ;
            endcase
        end else if (xfer) begin
            cur_addr <= cur_addr + `MEM_ADDR_W'(cfg_stride);
            cur_data <= cur_data + 1'b1;
        end
    end

    assign req_valid = active;
    assign req_addr  = cur_addr;
    assign req_data  = cur_data;
    assign busy      = active;

endmodule

`default_nettype wire

// ==== design/mem_arb.sv ====
/*
 * Two-way round-robin merge onto a credited, write-only memory port.
 * Output is registered and valid for one cycle per accepted request.
 * Each valid cycle uses one credit, each credit return pulse restores one.
 */
`include "cluster_defs.svh"

`default_nettype none

module mem_arb (
    input  wire                                        clk,
    input  wire                                        rst_n,

    input  wire  [`NUM_SOCKETS-1:0]                    req_valid,
    input  wire  [`NUM_SOCKETS-1:0][`MEM_ADDR_W-1:0]   req_addr,
    input  wire  [`NUM_SOCKETS-1:0][`MEM_DATA_W-1:0]   req_data,
    output logic [`NUM_SOCKETS-1:0]                    req_ready,

    output logic                                       mem_req_valid,
    output logic [`MEM_ADDR_W-1:0]                     mem_req_addr,
    output logic [`MEM_DATA_W-1:0]                     mem_req_data,
    output logic                                       mem_req_tag,
    input  wire                                        mem_credit_return,

    output logic                                       pending
);

    localparam int CNT_W = $clog2(`MEM_CREDITS + 1);

    logic [CNT_W-1:0]  credit_cnt;
    logic              rr_ptr;
    logic              can_accept;
    logic              grant_any;
    logic              grant_idx;

    // ********************
    // Grant
    // ********************

    // A credit still free once the registered request is counted
    assign can_accept = credit_cnt > CNT_W'(mem_req_valid);

    always_comb begin
        grant_idx = rr_ptr;
        if (!req_valid[rr_ptr]) begin
            grant_idx = ~rr_ptr;
        end
    end

    assign grant_any = can_accept && (|req_valid);
    assign req_ready = grant_any ? (`NUM_SOCKETS'(1) << grant_idx) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= 1'b0;
        end else if (grant_any) begin
            // Other socket first next time
            rr_ptr <= ~grant_idx;
        end
    end

    // ********************
    // Credits
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(`MEM_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(mem_req_valid) + CNT_W'(mem_credit_return);
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= grant_any;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_any) begin
            mem_req_addr <= req_addr[grant_idx];
            mem_req_data <= req_data[grant_idx];
            mem_req_tag  <= grant_idx;
        end
    end

    assign pending = mem_req_valid;

endmodule

`default_nettype wire

// ==== design/cluster.sv ====
/*
 * Fill cluster top. DCR writes go to two sockets through a router.
 * The socket streams merge in the arbiter. busy covers sockets and arbiter.
 */
`include "cluster_defs.svh"

`default_nettype none

module cluster import cluster_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,

    // DCR write bus
    input  wire                        dcr_write_valid,
    input  wire  [`DCR_ADDR_W-1:0]     dcr_write_addr,
    input  wire  dcr_data_u            dcr_write_data,

    // Memory write port
    output logic                       mem_req_valid,
    output logic [`MEM_ADDR_W-1:0]     mem_req_addr,
    output logic [`MEM_DATA_W-1:0]     mem_req_data,
    output logic                       mem_req_tag,
    input  wire                        mem_credit_return,

    output logic                       busy
);

    logic [`NUM_SOCKETS-1:0]                   reg_write;
    dcr_reg_e                                  reg_sel;
    dcr_data_u                                 reg_data;

    wire  [`NUM_SOCKETS-1:0]                   sock_req_valid;
    wire  [`NUM_SOCKETS-1:0][`MEM_ADDR_W-1:0]  sock_req_addr;
    wire  [`NUM_SOCKETS-1:0][`MEM_DATA_W-1:0]  sock_req_data;
    wire  [`NUM_SOCKETS-1:0]                   sock_req_ready;
    wire  [`NUM_SOCKETS-1:0]                   sock_busy;
    logic                                      arb_pending;

    dcr_router i_dcr_router (
        .clk             (clk),
        .rst_n           (rst_n),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .reg_write       (reg_write),
        .reg_sel         (reg_sel),
        .reg_data        (reg_data)
    );

    for (genvar i = 0; i < `NUM_SOCKETS; i++) begin : g_socket
        fill_socket #(
            .SOCKET_ID (i)
        ) i_fill_socket (
            .clk       (clk),
            .rst_n     (rst_n),
            .reg_write (reg_write[i]),
            .reg_sel   (reg_sel),
            .reg_data  (reg_data),
            .req_valid (sock_req_valid[i]),
            .req_addr  (sock_req_addr[i]),
            .req_data  (sock_req_data[i]),
            .req_ready (sock_req_ready[i]),
            .busy      (sock_busy[i])
        );
    end

    mem_arb i_mem_arb (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (sock_req_valid),
        .req_addr          (sock_req_addr),
        .req_data          (sock_req_data),
        .req_ready         (sock_req_ready),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_req_data      (mem_req_data),
        .mem_req_tag       (mem_req_tag),
        .mem_credit_return (mem_credit_return),
        .pending           (arb_pending)
    );

    // Arbiter still holding a write counts as busy
    assign busy = (|sock_busy) || arb_pending;

endmodule

`default_nettype wire

// ==== verif/cluster_assert.sv ====
/*
 * Concurrent checks on the memory port and busy, bound to the cluster top.
 * Outstanding writes are counted from the port, so credit returns
 * must never outnumber the writes issued.
 */
`include "cluster_defs.svh"

`default_nettype none

module cluster_assert (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    mem_req_valid,
    input wire [`MEM_ADDR_W-1:0]  mem_req_addr,
    input wire [`MEM_DATA_W-1:0]  mem_req_data,
    input wire                    mem_req_tag,
    input wire                    mem_credit_return,
    input wire                    busy
);

    logic [3:0] outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(mem_req_valid) - 4'(mem_credit_return);
        end
    end

    // ********************
    // Port properties
    // ********************
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !mem_req_valid && !busy)
        else $error("memory port or busy active during reset");

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= 4'(`MEM_CREDITS))
        else $error("more writes outstanding than credits");

    payload_known: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> !$isunknown({mem_req_addr, mem_req_data, mem_req_tag}))
        else $error("unknown payload on a valid write");

    // Idle cluster stays quiet
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |=> !mem_req_valid)
        else $error("write issued after busy fell");

endmodule

bind cluster cluster_assert i_cluster_assert (
    .clk               (clk),
    .rst_n             (rst_n),
    .mem_req_valid     (mem_req_valid),
    .mem_req_addr      (mem_req_addr),
    .mem_req_data      (mem_req_data),
    .mem_req_tag       (mem_req_tag),
    .mem_credit_return (mem_credit_return),
    .busy              (busy)
);

`default_nettype wire

// ==== verif/cluster_tb.sv ====
/*
 * Testbench for the fill cluster. One model queue pair per tag checks
 * every memory write. Credits return 0 to 5 cycles after each write
 * unless held back. Random stimulus uses a fixed seed.
 */
`include "cluster_defs.svh"

`default_nettype none

module cluster_tb import cluster_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;

    logic                    clk;
    logic                    rst_n;
    logic                    dcr_write_valid;
    logic [`DCR_ADDR_W-1:0]  dcr_write_addr;
    dcr_data_u               dcr_write_data;
    logic                    mem_req_valid;
    logic [`MEM_ADDR_W-1:0]  mem_req_addr;
    logic [`MEM_DATA_W-1:0]  mem_req_data;
    logic                    mem_req_tag;
    logic                    mem_credit_return;
    logic                    busy;

    // Expected writes per tag
    logic [31:0] exp_addr0 [$];
    logic [31:0] exp_data0 [$];
    logic [31:0] exp_addr1 [$];
    logic [31:0] exp_data1 [$];
    int          return_due [$];
    bit          hold_credits = 1'b0;
    int          cycle = 0;
    int          errors = 0;
    int          writes_seen = 0;
    int          last_write_cycle = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] cfg_base [2];
    logic [15:0] cfg_count [2];
    logic [15:0] cfg_stride [2];

    cluster i_cluster (
        .clk               (clk),
        .rst_n             (rst_n),
        .dcr_write_valid   (dcr_write_valid),
        .dcr_write_addr    (dcr_write_addr),
        .dcr_write_data    (dcr_write_data),
        .mem_req_valid     (mem_req_valid),
        .mem_req_addr      (mem_req_addr),
        .mem_req_data      (mem_req_data),
        .mem_req_tag       (mem_req_tag),
        .mem_credit_return (mem_credit_return),
        .busy              (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        repeat (20000) @(posedge clk);
        $display("Simulation limit reached before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    // ********************
    // Monitor and credits
    // ********************
    task automatic check_write(input logic tag, input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] want_addr;
        logic [31:0] want_data;
        int          depth;
        depth = tag ? exp_addr1.size() : exp_addr0.size();
        assert (depth > 0) else begin
            $display("Unexpected write at %0t on tag %0d with nothing left in its model", $time, tag);
            errors++;
        end
        if (depth > 0) begin
            want_addr = tag ? exp_addr1.pop_front() : exp_addr0.pop_front();
            want_data = tag ? exp_data1.pop_front() : exp_data0.pop_front();
            assert (addr == want_addr) else begin
                $display("Fail at %0t: mem_req_addr tag %0d expected %h got %h",
                         $time, tag, want_addr, addr);
                errors++;
            end
            assert (data == want_data) else begin
                $display("Fail at %0t: mem_req_data tag %0d expected %h got %h",
                         $time, tag, want_data, data);
                errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && mem_req_valid) begin
            check_write(mem_req_tag, mem_req_addr, mem_req_data);
            return_due.push_back(cycle + int'($urandom_range(5, 0)));
            writes_seen++;
            last_write_cycle = cycle;
        end
    end

    // At most one return per cycle, oldest first
    initial begin
        mem_credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            mem_credit_return = 1'b0;
            if (!hold_credits && return_due.size() > 0 && return_due[0] <= cycle) begin
                return_due.delete(0);
                mem_credit_return = 1'b1;
            end
        end
    end

    // ********************
    // Stimulus helpers
    // ********************
    function automatic logic [`DCR_ADDR_W-1:0] reg_addr(input int sock, input int off);
        return `DCR_ADDR_W'(`DCR_SOCKET_BEGIN + sock * `DCR_SOCKET_STRIDE + off);
    endfunction

    task automatic dcr_write(input logic [`DCR_ADDR_W-1:0] addr, input logic [31:0] data);
        dcr_write_valid     = 1'b1;
        dcr_write_addr      = addr;
        dcr_write_data.base = data;
        @(posedge clk);
        #1;
        dcr_write_valid = 1'b0;
    endtask

    task automatic config_socket(input int sock, input logic [31:0] base,
                                 input logic [15:0] count, input logic [15:0] stride);
        cfg_base[sock]   = base;
        cfg_count[sock]  = count;
        cfg_stride[sock] = stride;
        dcr_write(reg_addr(sock, REG_BASE), base);
        dcr_write(reg_addr(sock, REG_CFG), {count, stride});
    endtask

    // Model entry k is base + k * stride, seed + k
    task automatic start_socket(input int sock, input logic [31:0] seed);
        logic [31:0] addr;
        addr = cfg_base[sock];
        for (int k = 0; k < int'(cfg_count[sock]); k++) begin
            if (sock == 0) begin
                exp_addr0.push_back(addr);
                exp_data0.push_back(seed + 32'(k));
            end else begin
                exp_addr1.push_back(addr);
                exp_data1.push_back(seed + 32'(k));
            end
            addr = addr + {16'd0, cfg_stride[sock]};
        end
        dcr_write(reg_addr(sock, REG_START), seed);
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!busy && n < WAIT_LIMIT);
        assert (busy) else begin
            $display("Timeout at %0t: busy never rose after a job start", $time);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle(output int idle_cycle);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (busy && n < WAIT_LIMIT);
        idle_cycle = cycle;
        assert (!busy) else begin
            $display("Timeout at %0t: busy never fell after the job", $time);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_credits_home();
        int n;
        n = 0;
        while (return_due.size() > 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (return_due.size() == 0) else begin
            $display("Timeout at %0t: credits were not all returned", $time);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_drained(input int want_writes, input int first_seen);
        assert (exp_addr0.size() == 0 && exp_addr1.size() == 0) else begin
            $display("Writes missing at %0t: %0d left on tag 0 and %0d on tag 1",
                     $time, exp_addr0.size(), exp_addr1.size());
            errors++;
        end
        assert (writes_seen - first_seen == want_writes) else begin
            $display("Fail at %0t: mem_req_valid count expected %0d got %0d",
                     $time, want_writes, writes_seen - first_seen);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
        end
    endtask

    // ********************
    // Test sequence
    // ********************
    initial begin
        int          errs0;
        int          seen0;
        int          idle_cycle;
        logic [15:0] n0;
        logic [15:0] n1;
        void'($urandom(17));
        rst_n               = 1'b0;
        dcr_write_valid     = 1'b0;
        dcr_write_addr      = '0;
        dcr_write_data.base = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs0 = errors;
        assert (!mem_req_valid && !busy) else begin
            $display("Memory port or busy active right after reset");
            errors++;
        end
        finish_test(1, "reset", errs0);

        errs0 = errors;
        seen0 = writes_seen;
        config_socket(0, 32'h0000_1000, 16'd5, 16'd8);
        start_socket(0, 32'ha5a5_0000);
        wait_busy();
        wait_idle(idle_cycle);
        check_drained(5, seen0);
        finish_test(2, "single socket job", errs0);

        errs0 = errors;
        seen0 = writes_seen;
        n0 = 16'($urandom_range(16, 1));
        n1 = 16'($urandom_range(16, 1));
        config_socket(0, $urandom, n0, 16'($urandom));
        config_socket(1, $urandom, n1, 16'($urandom));
        // Back to back starts keep busy high across both jobs
        start_socket(0, $urandom);
        start_socket(1, $urandom);
        wait_busy();
        wait_idle(idle_cycle);
        check_drained(int'(n0) + int'(n1), seen0);
        finish_test(3, "both sockets", errs0);

        errs0 = errors;
        wait_credits_home();
        seen0 = writes_seen;
        hold_credits = 1'b1;
        config_socket(0, 32'h0001_0000, 16'd12, 16'd4);
        config_socket(1, 32'h0003_0000, 16'd12, 16'd64);
        start_socket(0, 32'h1000_0000);
        start_socket(1, 32'h2000_0000);
        repeat (30) @(posedge clk);
        #1;
        assert (writes_seen - seen0 == `MEM_CREDITS) else begin
            $display("Fail at %0t: mem_req_valid count with credits held expected %0d got %0d",
                     $time, `MEM_CREDITS, writes_seen - seen0);
            errors++;
        end
        hold_credits = 1'b0;
        wait_idle(idle_cycle);
        check_drained(24, seen0);
        finish_test(4, "credit back-pressure", errs0);

        errs0 = errors;
        seen0 = writes_seen;
        // Socket 1 armed but never started
        config_socket(1, 32'h0000_8000, 16'd3, 16'd4);
        config_socket(0, 32'h0000_4000, 16'd20, 16'd16);
        start_socket(0, 32'h0000_0100);
        wait_busy();
        dcr_write(12'h006, 32'h0000_0001);
        dcr_write(12'h01a, 32'h0000_0002);
        dcr_write(12'h116, 32'h0000_0003);
        dcr_write(reg_addr(0, 3), 32'h0000_0004);
        dcr_write(reg_addr(1, 3), 32'h0000_0005);
        dcr_write(reg_addr(0, REG_CFG), {16'd2, 16'd64});
        dcr_write(reg_addr(0, REG_START), 32'hdead_0000);
        assert (busy) else begin
            $display("Socket 0 finished before the ignored writes were made");
            errors++;
        end
        wait_idle(idle_cycle);
        check_drained(20, seen0);
        finish_test(5, "ignored writes", errs0);

        errs0 = errors;
        seen0 = writes_seen;
        config_socket(1, 32'h0002_0000, 16'd3, 16'd32);
        start_socket(1, 32'h7000_0000);
        wait_busy();
        wait_idle(idle_cycle);
        assert (idle_cycle == last_write_cycle + 1) else begin
            $display("Fail at %0t: busy fall cycle expected %0d got %0d",
                     $time, last_write_cycle + 1, idle_cycle);
            errors++;
        end
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            assert (!busy && !mem_req_valid) else begin
                $display("Activity at %0t after the job had completed", $time);
                errors++;
            end
        end
        check_drained(3, seen0);
        finish_test(6, "completion", errs0);

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d writes checked",
                 tests_run, tests_failed, errors, writes_seen);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/cluster_pkg.sv
design/dcr_router.sv
design/fill_socket.sv
design/mem_arb.sv
design/cluster.sv
verif/cluster_assert.sv
verif/cluster_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cluster_tb \
    -f build.f -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vcluster_tb > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q -e "Done: errors found" -e "Simulator exited with an error" sim.log && { echo "FAILED"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASSED" || { echo "FAILED"; exit 1; }
